//--- source/mem_bank_pkg.sv
/*
 * Banked memory front end shared definitions.
 * Holds the word widths, the Avalon-style request and response structs
 * and the response code carried beside read data and write responses.
 */

`default_nettype none

package mem_bank_pkg;

    // Largest supported bank count, sized to match bank_t
    localparam int MAX_BANKS = 4;

    typedef logic [15:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;
    typedef logic [1:0]  bank_t;

    // Avalon response encoding
    typedef enum logic [1:0] {
        resp_okay     = 2'b00,
        resp_reserved = 2'b01,
        resp_slverr   = 2'b10,
        resp_decerr   = 2'b11
    } resp_e;

    // One single-word command, either a read or a write
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        data_t writedata;
        be_t   byteenable;
    } mem_req_t;

    // One response beat; at most one of the two valids is high
    typedef struct packed {
        logic  readdatavalid;
        logic  writeresponsevalid;
        data_t readdata;
        resp_e response;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- source/mem_sync_fifo.sv
/*
 * Single-clock first-word-fall-through FIFO.
 * The head entry is visible on pop_data whenever the FIFO is not empty,
 * and free_slots reports the room left for the writer.
 */

`default_nettype none

module mem_sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 8
) (
    input  wire logic             mem_master,
    input  wire logic             reset,
    input  wire logic             push,
    input  wire logic [WIDTH-1:0] push_data,
    input  wire logic             pop,
    output logic [WIDTH-1:0]      pop_data,
    output logic                  empty,
    output logic                  full,
    output logic [$clog2(DEPTH+1)-1:0] free_slots
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] storage [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // Pointers wrap at DEPTH so that depths other than a power of two work
    function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A push into a full FIFO or a pop from an empty one is ignored
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge mem_master)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= bump(wr_ptr);
            if (do_pop)
                rd_ptr <= bump(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge mem_master)
    begin
        if (do_push)
            storage[wr_ptr] <= push_data;
    end

    // Fall-through read of the oldest entry
    assign pop_data   = storage[rd_ptr];
    assign empty      = (count == '0);
    assign full       = (count == CNT_W'(DEPTH));
    assign free_slots = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

//--- source/mem_bank_shim.sv
/*
 * Per-bank buffering shim between the dispatcher and one memory bank.
 * Queues commands toward the bank and responses back to the merger, and
 * can drive its waitrequest as an almost-full flag with a fixed slack.
 */

`default_nettype none

module mem_bank_shim import mem_bank_pkg::*; #(
    parameter int CMD_DEPTH         = 8,
    parameter int RSP_DEPTH         = 8,
    parameter int ALMFULL_THRESHOLD = 2
) (
    input  wire logic     mem_master,
    input  wire logic     reset,
    input  wire mem_req_t cmd_in,
    output logic          cmd_waitrequest,
    output mem_req_t      cmd_out,
    input  wire logic     cmd_out_waitrequest,
    input  wire mem_rsp_t rsp_in,
    output mem_rsp_t      rsp_out,
    input  wire logic     rsp_pop
);

    localparam int CMD_CNT_W = $clog2(CMD_DEPTH + 1);

    // Response entries keep only the kind, the data and the code
    typedef struct packed {
        logic  is_write;
        data_t readdata;
        resp_e response;
    } rsp_entry_t;

    mem_req_t             cmd_head;
    logic                 cmd_valid;
    logic                 cmd_empty;
    logic                 cmd_full;
    logic [CMD_CNT_W-1:0] cmd_free;
    logic                 cmd_issue;

    rsp_entry_t rsp_entry;
    rsp_entry_t rsp_head;
    logic       rsp_valid;
    logic       rsp_empty;
    logic       rsp_full;

    assign cmd_valid = cmd_in.read || cmd_in.write;

    mem_sync_fifo #(
        .WIDTH ($bits(mem_req_t)),
        .DEPTH (CMD_DEPTH)
    ) i_cmd_fifo (
        .mem_master (mem_master),
        .reset      (reset),
        .push       (cmd_valid && !cmd_full),
        .push_data  (cmd_in),
        .pop        (cmd_issue),
        .pop_data   (cmd_head),
        .empty      (cmd_empty),
        .full       (cmd_full),
        .free_slots (cmd_free)
    );

    // The head command is offered to the bank until the bank takes it
    always_comb
    begin
        cmd_out       = cmd_head;
        cmd_out.read  = cmd_head.read && !cmd_empty;
        cmd_out.write = cmd_head.write && !cmd_empty;
    end

    assign cmd_issue = (cmd_out.read || cmd_out.write) && !cmd_out_waitrequest;

    // Read data and write responses share one queue so they stay in bank order
    assign rsp_valid          = rsp_in.readdatavalid || rsp_in.writeresponsevalid;
    assign rsp_entry.is_write = rsp_in.writeresponsevalid;
    assign rsp_entry.readdata = rsp_in.readdata;
    assign rsp_entry.response = rsp_in.response;

    mem_sync_fifo #(
        .WIDTH ($bits(rsp_entry_t)),
        .DEPTH (RSP_DEPTH)
    ) i_rsp_fifo (
        .mem_master (mem_master),
        .reset      (reset),
        .push       (rsp_valid),
        .push_data  (rsp_entry),
        .pop        (rsp_pop),
        .pop_data   (rsp_head),
        .empty      (rsp_empty),
        .full       (rsp_full),
        .free_slots ()
    );

    assign rsp_out.readdatavalid      = !rsp_empty && !rsp_head.is_write;
    assign rsp_out.writeresponsevalid = !rsp_empty && rsp_head.is_write;
    assign rsp_out.readdata           = rsp_head.readdata;
    assign rsp_out.response           = rsp_head.response;

    generate
        if (ALMFULL_THRESHOLD == 0)
        begin : g_plain_wait
            // Ordinary Avalon back-pressure straight from the full flag
            assign cmd_waitrequest = cmd_full;
        end
        else
        begin : g_almfull_wait
            // Registered almost-full flag, so up to ALMFULL_THRESHOLD commands
            // may still land after it rises
            always_ff @(posedge mem_master)
            begin
                if (reset)
                    cmd_waitrequest <= 1'b1;
                else
                    cmd_waitrequest <= cmd_full ||
                        (cmd_free <= CMD_CNT_W'(ALMFULL_THRESHOLD));
            end

            // The upstream master must have honored the lagging flag in time
            a_no_cmd_when_full : assert property (
                @(posedge mem_master) disable iff (reset) cmd_valid |-> !cmd_full)
                else $error("%m: command arrived with the command buffer full");
        end
    endgenerate

    // Outstanding commands are bounded, so the bank can never overrun us
    a_no_rsp_when_full : assert property (
        @(posedge mem_master) disable iff (reset) rsp_valid |-> !rsp_full)
        else $error("%m: response arrived with the response buffer full");

endmodule

`default_nettype wire

//--- source/mem_bank_dispatch.sv
/*
 * Host command dispatcher.
 * Picks the bank from the low word-address bits, forwards each accepted
 * command to that bank only and records its bank in the order FIFO.
 */

`default_nettype none

module mem_bank_dispatch import mem_bank_pkg::*; #(
    parameter int NUM_BANKS = 4
) (
    input  wire logic     mem_master,
    input  wire logic     reset,
    input  wire mem_req_t host_req,
    output logic          host_waitrequest,
    output mem_req_t      bank_req [NUM_BANKS],
    input  wire logic     shim_waitrequest [NUM_BANKS],
    output logic          order_push,
    output bank_t         order_bank,
    input  wire logic     order_full
);

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic  init_done;
    logic  req_valid;
    logic  accept;
    bank_t sel_bank;
    addr_t local_addr;

    // Holds the host off for the first cycle after reset
    always_ff @(posedge mem_master)
    begin
        if (reset)
            init_done <= 1'b0;
        else
            init_done <= 1'b1;
    end

    assign req_valid = host_req.read || host_req.write;

    // Low word-address bits pick the bank and the rest form the bank address
    assign sel_bank   = bank_t'(host_req.address[BANK_W-1:0]);
    assign local_addr = host_req.address >> BANK_W;

    // Only the shim that this command targets can stall the host
    assign host_waitrequest = !init_done || order_full || shim_waitrequest[sel_bank];

    assign accept = req_valid && !host_waitrequest;

    // Each bank sees the command only in the cycle the host hands it over
    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            bank_req[b]         = host_req;
            bank_req[b].address = local_addr;
            bank_req[b].read    = host_req.read && accept && (sel_bank == bank_t'(b));
            bank_req[b].write   = host_req.write && accept && (sel_bank == bank_t'(b));
        end
    end

    // The merger replays responses in this order
    assign order_push = accept;
    assign order_bank = sel_bank;

endmodule

`default_nettype wire

//--- source/mem_resp_merge.sv
/*
 * Response merger.
 * Keeps the issue order of host commands as a queue of bank indices and
 * forwards bank responses to the host strictly in that order.
 */

`default_nettype none

module mem_resp_merge import mem_bank_pkg::*; #(
    parameter int NUM_BANKS   = 4,
    parameter int ORDER_DEPTH = 16
) (
    input  wire logic     mem_master,
    input  wire logic     reset,
    input  wire logic     order_push,
    input  wire bank_t    order_bank,
    output logic          order_full,
    input  wire mem_rsp_t shim_rsp [NUM_BANKS],
    output logic          shim_rsp_pop [NUM_BANKS],
    output mem_rsp_t      host_rsp
);

    bank_t    head_bank;
    mem_rsp_t head_rsp;
    logic     order_empty;
    logic     head_valid;
    logic     any_rsp;

    mem_sync_fifo #(
        .WIDTH ($bits(bank_t)),
        .DEPTH (ORDER_DEPTH)
    ) i_order_fifo (
        .mem_master (mem_master),
        .reset      (reset),
        .push       (order_push),
        .push_data  (order_bank),
        .pop        (head_valid),
        .pop_data   (head_bank),
        .empty      (order_empty),
        .full       (order_full),
        .free_slots ()
    );

    // Only the bank owning the oldest command may answer
    assign head_rsp   = shim_rsp[head_bank];
    assign head_valid = !order_empty &&
                        (head_rsp.readdatavalid || head_rsp.writeresponsevalid);

    always_comb
    begin
        host_rsp                    = head_rsp;
        host_rsp.readdatavalid      = head_rsp.readdatavalid && head_valid;
        host_rsp.writeresponsevalid = head_rsp.writeresponsevalid && head_valid;
    end

    // Pop the shim in the same cycle that its response goes to the host
    always_comb
    begin
        any_rsp = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            shim_rsp_pop[b] = head_valid && (head_bank == bank_t'(b));
            any_rsp         = any_rsp || shim_rsp[b].readdatavalid ||
                              shim_rsp[b].writeresponsevalid;
        end
    end

    // Every buffered response belongs to a command still in the order queue
    a_rsp_has_order : assert property (
        @(posedge mem_master) disable iff (reset) any_rsp |-> !order_empty)
        else $error("%m: bank response with no outstanding command");

endmodule

`default_nettype wire

//--- source/mem_bank_top.sv
/*
 * Banked memory front end top level.
 * One Avalon-style host port fans out to NUM_BANKS buffered bank ports
 * and responses come back in host issue order.
 */

`default_nettype none

module mem_bank_top import mem_bank_pkg::*; #(
    parameter int NUM_BANKS         = 4,
    parameter int CMD_DEPTH         = 8,
    parameter int RSP_DEPTH         = 8,
    parameter int ALMFULL_THRESHOLD = 2,
    parameter int ORDER_DEPTH       = 16
) (
    input  wire logic     mem_master,
    input  wire logic     reset,
    input  wire mem_req_t host_req,
    output logic          host_waitrequest,
    output mem_rsp_t      host_rsp,
    output mem_req_t      mem_req [NUM_BANKS],
    input  wire logic     mem_waitrequest [NUM_BANKS],
    input  wire mem_rsp_t mem_rsp [NUM_BANKS]
);

    mem_req_t bank_req [NUM_BANKS];
    logic     shim_waitrequest [NUM_BANKS];
    mem_rsp_t shim_rsp [NUM_BANKS];
    logic     shim_rsp_pop [NUM_BANKS];
    logic     order_push;
    bank_t    order_bank;
    logic     order_full;

    // Bank decode uses a power-of-two count no larger than bank_t allows
    if (NUM_BANKS != 2 && NUM_BANKS != MAX_BANKS)
    begin : g_bad_banks
        $error("NUM_BANKS must be 2 or %0d", MAX_BANKS);
    end

    mem_bank_dispatch #(
        .NUM_BANKS (NUM_BANKS)
    ) i_dispatch (
        .mem_master       (mem_master),
        .reset            (reset),
        .host_req         (host_req),
        .host_waitrequest (host_waitrequest),
        .bank_req         (bank_req),
        .shim_waitrequest (shim_waitrequest),
        .order_push       (order_push),
        .order_bank       (order_bank),
        .order_full       (order_full)
    );

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        mem_bank_shim #(
            .CMD_DEPTH         (CMD_DEPTH),
            .RSP_DEPTH         (RSP_DEPTH),
            .ALMFULL_THRESHOLD (ALMFULL_THRESHOLD)
        ) i_shim (
            .mem_master          (mem_master),
            .reset               (reset),
            .cmd_in              (bank_req[b]),
            .cmd_waitrequest     (shim_waitrequest[b]),
            .cmd_out             (mem_req[b]),
            .cmd_out_waitrequest (mem_waitrequest[b]),
            .rsp_in              (mem_rsp[b]),
            .rsp_out             (shim_rsp[b]),
            .rsp_pop             (shim_rsp_pop[b])
        );
    end

    mem_resp_merge #(
        .NUM_BANKS   (NUM_BANKS),
        .ORDER_DEPTH (ORDER_DEPTH)
    ) i_merge (
        .mem_master   (mem_master),
        .reset        (reset),
        .order_push   (order_push),
        .order_bank   (order_bank),
        .order_full   (order_full),
        .shim_rsp     (shim_rsp),
        .shim_rsp_pop (shim_rsp_pop),
        .host_rsp     (host_rsp)
    );

endmodule

`default_nettype wire

//--- dv/tb_bank_model.sv
/*
 * Behavioral memory bank for the banked memory testbench.
 * Accepts single-word commands with random waitrequest, answers them in
 * order after a random delay and flags the all-ones local address.
 */

`default_nettype none

module tb_bank_model import mem_bank_pkg::*; #(
    parameter addr_t LOCAL_MAX    = 16'h3FFF,
    parameter int    DELAY_BASE   = 1,
    parameter int    DELAY_SPREAD = 2,
    parameter int    MAX_PENDING  = 8
) (
    input  wire logic     mem_master,
    input  wire logic     reset,
    input  wire logic     hold,
    input  wire mem_req_t mem_req,
    output logic          mem_waitrequest,
    output mem_rsp_t      mem_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    // A response waiting for its release cycle
    typedef struct packed {
        mem_rsp_t    rsp;
        logic [31:0] due;
    } pending_t;

    data_t       storage [addr_t];
    pending_t    pending [$];
    logic [31:0] cycle;

    // Locations never written read back as zero
    function automatic data_t read_word(input addr_t a);
        return storage.exists(a) ? storage[a] : '0;
    endfunction

    // Executes one command at once and queues its response
    function automatic void take_command();
        pending_t entry;
        data_t    word;
        entry = '0;
        entry.due = cycle + 32'(DELAY_BASE) + $urandom_range(0, DELAY_SPREAD);
        entry.rsp.response = (mem_req.address == LOCAL_MAX) ? resp_slverr : resp_okay;
        if (mem_req.write)
        begin
            entry.rsp.writeresponsevalid = 1'b1;
            // A failing write leaves the memory untouched
            if (entry.rsp.response == resp_okay)
            begin
                word = read_word(mem_req.address);
                for (int i = 0; i < 4; i++)
                begin
                    if (mem_req.byteenable[i])
                        word[8*i +: 8] = mem_req.writedata[8*i +: 8];
                end
                storage[mem_req.address] = word;
            end
        end
        else
        begin
            entry.rsp.readdatavalid = 1'b1;
            if (entry.rsp.response == resp_okay)
                entry.rsp.readdata = read_word(mem_req.address);
        end
        pending.push_back(entry);
    endfunction

    // Commands are taken at the falling edge, outputs change just after the rising edge
    initial
    begin
        pending_t entry;
        mem_waitrequest = 1'b1;
        mem_rsp = '0;
        cycle = '0;
        forever
        begin
            @(negedge mem_master);
            if (!reset && (mem_req.read || mem_req.write) && !mem_waitrequest)
                take_command();
            @(posedge mem_master);
            #1;
            cycle = cycle + 1;
            mem_rsp = '0;
            // Responses leave strictly in the order the commands came in
            if (!reset && pending.size() != 0 && pending[0].due <= cycle)
            begin
                entry = pending.pop_front();
                mem_rsp = entry.rsp;
            end
            mem_waitrequest = reset || hold || (pending.size() >= MAX_PENDING) ||
                              ($urandom_range(0, 3) == 0);
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_mem_bank.sv
/*
 * Testbench for the banked memory front end.
 * Drives host commands, keeps a shadow memory of the banks and checks
 * that every response returns in issue order with the right data and code.
 */

`default_nettype none

module tb_mem_bank import mem_bank_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    NUM_BANKS = 4;
    localparam int    CMD_DEPTH = 8;
    localparam int    RSP_DEPTH = 8;
    localparam int    BANK_W    = 2;
    localparam int    TIMEOUT   = 200;
    localparam addr_t LOCAL_MAX = addr_t'(16'hFFFF >> BANK_W);

    // What the host should see for one accepted command
    typedef struct packed {
        logic  is_write;
        data_t data;
        resp_e code;
    } expect_t;

    logic          mem_master;
    logic          reset;
    mem_req_t      host_req;
    logic          host_waitrequest;
    mem_rsp_t      host_rsp;
    mem_req_t      mem_req [NUM_BANKS];
    wire logic     mem_waitrequest [NUM_BANKS];
    wire mem_rsp_t mem_rsp [NUM_BANKS];
    logic          hold [NUM_BANKS];

    data_t   shadow [addr_t];
    expect_t scoreboard [$];
    int      accepted;
    int      responses;
    int      bank_cmds;

    mem_bank_top #(
        .NUM_BANKS         (NUM_BANKS),
        .CMD_DEPTH         (CMD_DEPTH),
        .RSP_DEPTH         (RSP_DEPTH),
        .ALMFULL_THRESHOLD (2),
        .ORDER_DEPTH       (16)
    ) i_dut (
        .mem_master       (mem_master),
        .reset            (reset),
        .host_req         (host_req),
        .host_waitrequest (host_waitrequest),
        .host_rsp         (host_rsp),
        .mem_req          (mem_req),
        .mem_waitrequest  (mem_waitrequest),
        .mem_rsp          (mem_rsp)
    );

    // Higher banks answer more slowly so responses overtake each other inside the DUT
    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_model
        tb_bank_model #(
            .LOCAL_MAX    (LOCAL_MAX),
            .DELAY_BASE   (1 + 4 * b),
            .DELAY_SPREAD (3),
            .MAX_PENDING  (RSP_DEPTH)
        ) i_model (
            .mem_master      (mem_master),
            .reset           (reset),
            .hold            (hold[b]),
            .mem_req         (mem_req[b]),
            .mem_waitrequest (mem_waitrequest[b]),
            .mem_rsp         (mem_rsp[b])
        );
    end

    always #4 mem_master = ~mem_master;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_resp(input string name, input resp_e got, input resp_e exp);
        if (got !== exp)
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_kind(input logic got_is_write, input logic exp_is_write);
        if (got_is_write !== exp_is_write)
            report_failure($sformatf("FAILED host_rsp.writeresponsevalid: got %h expected %h",
                                     got_is_write, exp_is_write));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("FAILED %s: got %h expected %h", name, got, exp));
    endtask

    function automatic data_t merge_bytes(input data_t old, input data_t wdata, input be_t be);
        data_t word;
        word = old;
        for (int i = 0; i < 4; i++)
        begin
            if (be[i])
                word[8*i +: 8] = wdata[8*i +: 8];
        end
        return word;
    endfunction

    // Read result from the shadow, zero where nothing was written
    function automatic data_t expected_read(input addr_t a);
        return shadow.exists(a) ? shadow[a] : '0;
    endfunction

    // The all-ones bank-local address is the error location of each bank
    function automatic resp_e expected_code(input addr_t a);
        return (addr_t'(a >> BANK_W) == LOCAL_MAX) ? resp_slverr : resp_okay;
    endfunction

    function automatic void record_accept(input mem_req_t req);
        expect_t exp;
        exp.is_write = req.write;
        exp.code = expected_code(req.address);
        exp.data = expected_read(req.address);
        if (req.write && exp.code == resp_okay)
            shadow[req.address] = merge_bytes(exp.data, req.writedata, req.byteenable);
        scoreboard.push_back(exp);
        accepted++;
    endfunction

    // Presents one command and holds it until the DUT takes it
    task automatic issue(input logic is_write, input addr_t a, input data_t d, input be_t be);
        int   waited;
        logic taken;
        waited = 0;
        taken = 1'b0;
        // Outstanding commands never exceed what one response buffer can hold
        while (accepted - responses >= RSP_DEPTH)
        begin
            @(posedge mem_master);
            #1;
            waited++;
            if (waited > TIMEOUT)
                report_failure("timeout waiting for outstanding responses to return");
        end
        host_req = '0;
        host_req.read = !is_write;
        host_req.write = is_write;
        host_req.address = a;
        host_req.writedata = d;
        host_req.byteenable = be;
        while (!taken)
        begin
            // Waitrequest is settled at the falling edge and decides the next rising one
            @(negedge mem_master);
            taken = !host_waitrequest;
            if (taken)
                record_accept(host_req);
            @(posedge mem_master);
            #1;
            waited++;
            if (!taken && waited > TIMEOUT)
                report_failure("timeout waiting for the DUT to accept a command");
        end
        host_req.read = 1'b0;
        host_req.write = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (scoreboard.size() != 0)
        begin
            @(posedge mem_master);
            #1;
            waited++;
            if (waited > TIMEOUT)
                report_failure("timeout waiting for the last responses");
        end
    endtask

    // Bank 0 refuses commands while the other banks keep flowing
    task automatic stall_one_bank();
        int   taken;
        logic stalled;
        taken = 0;
        stalled = 1'b0;
        hold[0] = 1'b1;
        @(posedge mem_master);
        #1;
        while (!stalled)
        begin
            host_req = '0;
            host_req.write = 1'b1;
            host_req.address = addr_t'(taken << BANK_W);
            host_req.writedata = data_t'(32'hB000_0000 + taken);
            host_req.byteenable = 4'hF;
            @(negedge mem_master);
            stalled = host_waitrequest;
            if (!stalled)
            begin
                record_accept(host_req);
                taken++;
            end
            @(posedge mem_master);
            #1;
            if (taken > CMD_DEPTH)
                report_failure("bank 0 never pushed back while its memory was held");
        end
        if (taken == 0)
            report_failure("bank 0 refused its first command while its buffer was empty");
        // The refused bank 0 command stays on the bus and must keep stalling
        for (int i = 0; i < 4; i++)
        begin
            @(negedge mem_master);
            check_flag("host_waitrequest", host_waitrequest, 1'b1);
            @(posedge mem_master);
            #1;
        end
        // Bank 1 still accepts, and its data must wait behind bank 0
        issue(1'b0, 16'h0041, '0, 4'hF);
        hold[0] = 1'b0;
    endtask

    // Commands the bank models took, counted at the bank ports of the DUT
    always @(negedge mem_master)
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (!reset && (mem_req[b].read || mem_req[b].write) && !mem_waitrequest[b])
                bank_cmds++;
        end
    end

    // Compares each host response with the oldest scoreboard entry
    always @(negedge mem_master)
    begin
        expect_t head;
        if (!reset && (host_rsp.readdatavalid || host_rsp.writeresponsevalid))
        begin
            if (scoreboard.size() == 0)
                report_failure("host response arrived with no command outstanding");
            head = scoreboard.pop_front();
            check_kind(host_rsp.writeresponsevalid, head.is_write);
            check_flag("host_rsp.readdatavalid", host_rsp.readdatavalid, !head.is_write);
            check_resp("host_rsp.response", host_rsp.response, head.code);
            if (!head.is_write && head.code == resp_okay)
                check_data("host_rsp.readdata", host_rsp.readdata, head.data);
            responses++;
        end
    end

    initial
    begin
        addr_t a;
        void'($urandom(17));
        mem_master = 1'b0;
        reset = 1'b1;
        host_req = '0;
        accepted = 0;
        responses = 0;
        bank_cmds = 0;
        for (int b = 0; b < NUM_BANKS; b++)
            hold[b] = 1'b0;
        repeat (3) @(posedge mem_master);
        #1;
        reset = 1'b0;

        // One write and its read back in every bank
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            issue(1'b1, addr_t'(16'h0040 + b), data_t'(32'hC0DE_0000 + b), 4'hF);
            issue(1'b0, addr_t'(16'h0040 + b), '0, 4'hF);
        end
        drain();

        // Partial byte lanes merge into the stored word
        issue(1'b1, 16'h0106, 32'h1122_3344, 4'hF);
        issue(1'b1, 16'h0106, 32'hAABB_CCDD, 4'b0101);
        issue(1'b0, 16'h0106, '0, 4'hF);
        drain();

        // Host addresses 0xFFFC to 0xFFFF hit the all-ones local word of each bank
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            issue(1'b1, addr_t'(16'hFFFC + b), 32'hDEAD_BEEF, 4'hF);
            issue(1'b0, addr_t'(16'hFFFC + b), '0, 4'hF);
        end
        drain();

        // Random traffic spread over all banks with unequal latencies
        for (int i = 0; i < 60; i++)
        begin
            a = addr_t'(($urandom_range(0, 7) << BANK_W) + $urandom_range(0, NUM_BANKS - 1));
            issue($urandom_range(0, 1) == 1, a, $urandom(), be_t'($urandom_range(1, 15)));
        end
        drain();

        stall_one_bank();
        drain();

        $display("%0d commands issued, %0d responses checked", accepted, responses);
        if (responses == bank_cmds)
        begin
            $display("Regression passed");
            $finish;
        end
        else
            report_failure($sformatf("FAILED response count: got %h expected %h",
                                     responses, bank_cmds));
    end

endmodule

`default_nettype wire

//--- sim.f
source/mem_bank_pkg.sv
source/mem_sync_fifo.sv
source/mem_bank_shim.sv
source/mem_bank_dispatch.sv
source/mem_resp_merge.sv
source/mem_bank_top.sv
dv/tb_bank_model.sv
dv/tb_mem_bank.sv

//--- Makefile
# Verilator build and run for the banked memory front end

BIN := obj_dir/Vtb_mem_bank
SRCS := $(wildcard source/*.sv dv/*.sv)

.PHONY: run clean

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

$(BIN): sim.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_mem_bank \
		-f sim.f -o Vtb_mem_bank

clean:
	rm -rf obj_dir
